//--- all.f
+incdir+tb
source/rx_pkg.sv
source/stream_skid.sv
source/frame_header_decoder.sv
source/run_statistics.sv
source/report_emitter.sv
source/readout_monitor_top.sv
tb/tb_readout_monitor.sv

//--- source/frame_header_decoder.sv
`timescale 1ns/1ps

module frame_header_decoder #(
    parameter int TDATA_WIDTH = 128
) (
    input  logic                   ACLK,
    input  logic                   ARESETN,
    input  logic [TDATA_WIDTH-1:0] beat,
    input  logic                   beat_valid,
    output logic                   beat_ready,
    output rx_pkg::frame_header_t  hdr,
    output logic                   hdr_valid,
    input  logic                   hdr_ready
);

    // ##############################
    // field positions
    // ##############################

    localparam int ID_LSB      = rx_pkg::DF_ID_MSB - $bits(rx_pkg::HEADER_ID) + 1;
    localparam int CHANNEL_MSB = ID_LSB - 1;
    localparam int LENGTH_MSB  = CHANNEL_MSB - rx_pkg::CHANNEL_WIDTH;
    localparam int INFO_MSB    = LENGTH_MSB - rx_pkg::LENGTH_WIDTH;

    if (TDATA_WIDTH < rx_pkg::DF_ID_MSB + 1) begin : g_width_check
        $error("TDATA_WIDTH must hold at least one 64-bit dataframe word");
    end

    logic [rx_pkg::DF_ID_MSB:0]    frame;
    logic [rx_pkg::INFO_WIDTH-1:0] info;
    rx_pkg::frame_header_t         decoded;
    logic                          beat_fire;

    // only the low dataframe word of the beat carries a header
    assign frame = beat[rx_pkg::DF_ID_MSB:0];
    assign info  = frame[INFO_MSB -: rx_pkg::INFO_WIDTH];

    always_comb begin
        decoded.is_header   = (frame[rx_pkg::DF_ID_MSB:ID_LSB] == rx_pkg::HEADER_ID);
        decoded.channel     = frame[CHANNEL_MSB -: rx_pkg::CHANNEL_WIDTH];
        decoded.length      = frame[LENGTH_MSB -: rx_pkg::LENGTH_WIDTH];
        decoded.run_end     = (info[3:2] == 2'b10);
        decoded.first_frame = info[1];
        decoded.not_last    = info[0];
    end

    // ##############################
    // pipeline register
    // ##############################

    assign beat_ready = !hdr_valid || hdr_ready;
    assign beat_fire  = beat_valid && beat_ready;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            hdr_valid <= 1'b0;
        end else if (beat_ready) begin
            hdr_valid <= beat_valid;
        end
    end

    // non-header beats still pass so the window sees every accepted beat
    always_ff @(posedge ACLK) begin
        if (beat_fire) begin
            hdr <= decoded;
        end
    end

endmodule

//--- source/readout_monitor_top.sv
`timescale 1ns/1ps

module readout_monitor_top #(
    parameter int TDATA_WIDTH  = 128,
    parameter int WINDOW_WIDTH = 20
) (
    input  logic                   ACLK,
    input  logic                   ARESETN,

    input  logic [TDATA_WIDTH-1:0] s_tdata,
    input  logic                   s_tvalid,
    output logic                   s_tready,

    output logic [31:0]            received_size,
    output logic [30:0]            hit_count,
    output logic                   full,

    output rx_pkg::run_report_t    m_report,
    output logic                   m_valid,
    input  logic                   m_ready
);

    logic [TDATA_WIDTH-1:0] beat;
    logic                   beat_valid;
    logic                   beat_ready;
    rx_pkg::frame_header_t  hdr;
    logic                   hdr_valid;
    logic                   hdr_ready;
    rx_pkg::run_report_t    snap;
    logic                   snap_valid;
    logic                   snap_ready;

    // ##############################
    // input side
    // ##############################

    stream_skid #(
        .item_t(logic [TDATA_WIDTH-1:0])
    ) u_in_skid (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .in_data  (s_tdata),
        .in_valid (s_tvalid),
        .in_ready (s_tready),
        .out_data (beat),
        .out_valid(beat_valid),
        .out_ready(beat_ready)
    );

    // ##############################
    // processing
    // ##############################

    frame_header_decoder #(
        .TDATA_WIDTH(TDATA_WIDTH)
    ) u_decoder (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .beat      (beat),
        .beat_valid(beat_valid),
        .beat_ready(beat_ready),
        .hdr       (hdr),
        .hdr_valid (hdr_valid),
        .hdr_ready (hdr_ready)
    );

    run_statistics #(
        .WINDOW_WIDTH(WINDOW_WIDTH)
    ) u_stats (
        .ACLK         (ACLK),
        .ARESETN      (ARESETN),
        .hdr          (hdr),
        .hdr_valid    (hdr_valid),
        .hdr_ready    (hdr_ready),
        .received_size(received_size),
        .hit_count    (hit_count),
        .full         (full),
        .snap         (snap),
        .snap_valid   (snap_valid),
        .snap_ready   (snap_ready)
    );

    // ##############################
    // output side
    // ##############################

    report_emitter u_emitter (
        .ACLK      (ACLK),
        .ARESETN   (ARESETN),
        .snap      (snap),
        .snap_valid(snap_valid),
        .snap_ready(snap_ready),
        .m_report  (m_report),
        .m_valid   (m_valid),
        .m_ready   (m_ready)
    );

endmodule

//--- source/report_emitter.sv
`timescale 1ns/1ps

module report_emitter (
    input  logic                ACLK,
    input  logic                ARESETN,
    input  rx_pkg::run_report_t snap,
    input  logic                snap_valid,
    output logic                snap_ready,
    output rx_pkg::run_report_t m_report,
    output logic                m_valid,
    input  logic                m_ready
);

    rx_pkg::run_report_t report_q;
    logic                report_valid;
    logic                skid_ready;
    logic                snap_fire;
    logic [15:0]         run_index;

    assign snap_ready = !report_valid || skid_ready;
    assign snap_fire  = snap_valid && snap_ready;

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            report_valid <= 1'b0;
            run_index    <= '0;
        end else if (snap_ready) begin
            report_valid <= snap_valid;
            if (snap_valid) begin
                run_index <= run_index + 16'd1;
            end
        end
    end

    // reports are numbered in the order they leave the statistics block
    always_ff @(posedge ACLK) begin
        if (snap_fire) begin
            report_q           <= snap;
            report_q.run_index <= run_index;
        end
    end

    // ##############################
    // output stage
    // ##############################

    stream_skid #(
        .item_t(rx_pkg::run_report_t)
    ) u_out_skid (
        .ACLK     (ACLK),
        .ARESETN  (ARESETN),
        .in_data  (report_q),
        .in_valid (report_valid),
        .in_ready (skid_ready),
        .out_data (m_report),
        .out_valid(m_valid),
        .out_ready(m_ready)
    );

endmodule

//--- source/run_statistics.sv
`timescale 1ns/1ps

module run_statistics #(
    parameter int WINDOW_WIDTH = 20
) (
    input  logic                  ACLK,
    input  logic                  ARESETN,
    input  rx_pkg::frame_header_t hdr,
    input  logic                  hdr_valid,
    output logic                  hdr_ready,
    output logic [31:0]           received_size,
    output logic [30:0]           hit_count,
    output logic                  full,
    output rx_pkg::run_report_t   snap,
    output logic                  snap_valid,
    input  logic                  snap_ready
);

    logic [WINDOW_WIDTH-1:0] window_cnt;
    logic                    accept;
    logic                    is_run_end;
    logic                    window_wrap;
    logic [31:0]             size_add;
    logic [30:0]             hit_add;
    logic [31:0]             size_next;
    logic [30:0]             hit_next;
    logic                    full_next;

    assign is_run_end = hdr.is_header && hdr.run_end;

    // a run-end item waits until the snapshot slot is free
    assign hdr_ready = !is_run_end || !snap_valid || snap_ready;
    assign accept    = hdr_valid && hdr_ready;

    // ##############################
    // next values
    // ##############################

    assign window_wrap = &window_cnt;

    assign size_add = hdr.is_header
                    ? 32'(hdr.length) + rx_pkg::SIZE_OVERHEAD
                    : 32'd0;
    assign hit_add  = {30'd0, hdr.is_header && hdr.first_frame};

    assign size_next = received_size + size_add;

    // the wrapping beat starts the new window with its own hit only
    assign hit_next  = window_wrap ? hit_add : hit_count + hit_add;
    assign full_next = full || (is_run_end && hdr.not_last);

    // ##############################
    // accumulators
    // ##############################

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            window_cnt    <= '0;
            received_size <= '0;
            hit_count     <= '0;
            full          <= 1'b0;
        end else if (accept) begin
            window_cnt    <= window_cnt + 1'b1;
            received_size <= size_next;
            hit_count     <= hit_next;
            full          <= full_next;
        end
    end

    // ##############################
    // report snapshot
    // ##############################

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            snap_valid <= 1'b0;
        end else if (accept && is_run_end) begin
            snap_valid <= 1'b1;
        end else if (snap_ready) begin
            snap_valid <= 1'b0;
        end
    end

    // the run index is stamped later by the emitter
    always_ff @(posedge ACLK) begin
        if (accept && is_run_end) begin
            snap.run_index     <= '0;
            snap.received_size <= size_next;
            snap.hit_count     <= hit_next;
            snap.full          <= full_next;
            snap.last_channel  <= hdr.channel;
        end
    end

    a_hit_hold: assert property (@(posedge ACLK) disable iff (!ARESETN)
        !accept |=> $stable(hit_count));

endmodule

//--- source/rx_pkg.sv
package rx_pkg;

    // ##############################
    // dataframe header layout
    // ##############################

    // identifier in the top byte of the 64-bit dataframe word
    localparam logic [7:0] HEADER_ID = 8'hAA;
    localparam int DF_ID_MSB = 63;

    // field widths, packed downward directly below the identifier
    localparam int CHANNEL_WIDTH = 12;
    localparam int LENGTH_WIDTH = 12;
    localparam int INFO_WIDTH = 4;

    // header and footer words that are not counted in the frame length
    localparam logic [31:0] SIZE_OVERHEAD = 32'd4;

    // ##############################
    // shared structs
    // ##############################

    typedef struct packed {
        logic                     is_header;
        logic [CHANNEL_WIDTH-1:0] channel;
        logic [LENGTH_WIDTH-1:0]  length;
        logic                     run_end;
        logic                     first_frame;
        logic                     not_last;
    } frame_header_t;

    typedef struct packed {
        logic [15:0]              run_index;
        logic [31:0]              received_size;
        logic [30:0]              hit_count;
        logic                     full;
        logic [CHANNEL_WIDTH-1:0] last_channel;
    } run_report_t;

endpackage

//--- source/stream_skid.sv
`timescale 1ns/1ps

module stream_skid #(
    parameter type item_t = logic
) (
    input  logic  ACLK,
    input  logic  ARESETN,
    input  item_t in_data,
    input  logic  in_valid,
    output logic  in_ready,
    output item_t out_data,
    output logic  out_valid,
    input  logic  out_ready
);

    item_t      skid_data;
    logic       skid_valid;
    logic       ready_q;
    logic       in_fire;
    logic       out_fire;
    logic       load_out;
    logic [1:0] count_next;

    assign in_ready = ready_q;
    assign in_fire  = in_valid && ready_q;
    assign out_fire = out_valid && out_ready;
    assign load_out = !out_valid || out_ready;

    // occupancy after this edge, the ready for the next cycle comes from it
    assign count_next = {1'b0, out_valid} + {1'b0, skid_valid}
                      + {1'b0, in_fire} - {1'b0, out_fire};

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            ready_q <= 1'b0;
        end else begin
            ready_q <= (count_next < 2'd2);
        end
    end

    always_ff @(posedge ACLK) begin
        if (!ARESETN) begin
            out_valid  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (load_out) begin
            out_valid  <= skid_valid || in_fire;
            skid_valid <= 1'b0;
        end else if (in_fire) begin
            skid_valid <= 1'b1;
        end
    end

    // the held entry always leaves first so order is kept
    always_ff @(posedge ACLK) begin
        if (load_out) begin
            if (skid_valid) begin
                out_data <= skid_data;
            end else if (in_fire) begin
                out_data <= in_data;
            end
        end else if (in_fire) begin
            skid_data <= in_data;
        end
    end

    a_out_stable: assert property (@(posedge ACLK) disable iff (!ARESETN)
        out_valid && !out_ready |=> out_valid && $stable(out_data));

    // a third beat would overwrite the held entry
    a_no_overflow: assert property (@(posedge ACLK) disable iff (!ARESETN)
        skid_valid |-> !in_ready);

endmodule

//--- tb/monitor_model.svh
`ifndef MONITOR_MODEL_SVH
`define MONITOR_MODEL_SVH

// ##############################
// random numbers
// ##############################

logic [31:0] lcg_state = 32'h77aae57f;

function automatic logic [31:0] next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
endfunction

// ##############################
// reference model
// ##############################

logic [WINDOW_WIDTH-1:0] model_window = '0;
logic [31:0]             model_size   = '0;
logic [30:0]             model_hits   = '0;
logic                    model_full   = 1'b0;
int                      run_end_count = 0;
rx_pkg::run_report_t     expected_reports[$];

// header layout: id 63:56, channel 55:44, length 43:32, info 31:28
task automatic model_accept(input logic [TDATA_WIDTH-1:0] data);
    logic [3:0]          info;
    logic                run_end;
    logic [30:0]         hit_inc;
    rx_pkg::run_report_t rep;
    info    = data[31:28];
    run_end = 1'b0;
    hit_inc = '0;
    if (data[63:56] == 8'hAA) begin
        run_end    = (info[3:2] == 2'b10);
        hit_inc    = {30'd0, info[1]};
        model_size = model_size + 32'(data[43:32]) + 32'd4;
        if (run_end && info[0]) begin
            model_full = 1'b1;
        end
    end
    // the beat that wraps the window starts the count over
    if (model_window == '1) begin
        model_hits = hit_inc;
    end else begin
        model_hits = model_hits + hit_inc;
    end
    model_window = model_window + 1'b1;
    if (run_end) begin
        rep.run_index     = run_end_count[15:0];
        rep.received_size = model_size;
        rep.hit_count     = model_hits;
        rep.full          = model_full;
        rep.last_channel  = data[55:44];
        expected_reports.push_back(rep);
        run_end_count++;
    end
endtask

// ##############################
// checks
// ##############################

task automatic stop_with_failure();
    $display("=== FAIL ===");
    $fatal(1, "simulation stopped at the first error");
endtask

task automatic check_report(input rx_pkg::run_report_t got, input rx_pkg::run_report_t exp);
    if (got !== exp) begin
        $display("FAILED m_report: got %h expected %h", got, exp);
        stop_with_failure();
    end
endtask

task automatic check_size(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h expected %h", name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_count(input string name, input logic [30:0] got, input logic [30:0] exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h expected %h", name, got, exp);
        stop_with_failure();
    end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
        $display("FAILED %s: got %h expected %h", name, got, exp);
        stop_with_failure();
    end
endtask

`endif

//--- tb/tb_readout_monitor.sv
`timescale 1ns/1ps

module tb_readout_monitor;

    localparam int TDATA_WIDTH  = 128;
    localparam int WINDOW_WIDTH = 6;
    localparam int NUM_BEATS    = 2000;
    localparam int CLK_PERIOD   = 8;
    localparam int STALL_PERIOD = 600;
    localparam int STALL_LENGTH = 200;

    logic                   ACLK;
    logic                   ARESETN;
    logic [TDATA_WIDTH-1:0] s_tdata;
    logic                   s_tvalid;
    logic                   s_tready;
    logic [31:0]            received_size;
    logic [30:0]            hit_count;
    logic                   full;
    rx_pkg::run_report_t    m_report;
    logic                   m_valid;
    logic                   m_ready;

    int beats_sent       = 0;
    int reports_received = 0;
    bit stimulus_started = 1'b0;
    bit full_seen        = 1'b0;
    bit saw_backpressure = 1'b0;

    `include "monitor_model.svh"

    readout_monitor_top #(
        .TDATA_WIDTH (TDATA_WIDTH),
        .WINDOW_WIDTH(WINDOW_WIDTH)
    ) DUT (
        .ACLK         (ACLK),
        .ARESETN      (ARESETN),
        .s_tdata      (s_tdata),
        .s_tvalid     (s_tvalid),
        .s_tready     (s_tready),
        .received_size(received_size),
        .hit_count    (hit_count),
        .full         (full),
        .m_report     (m_report),
        .m_valid      (m_valid),
        .m_ready      (m_ready)
    );

    initial begin
        ACLK = 1'b0;
        forever #(CLK_PERIOD / 2) ACLK = ~ACLK;
    end

    initial begin
        #(NUM_BEATS * 20 * CLK_PERIOD);
        $display("timeout: the stream did not drain within the allowed time");
        stop_with_failure();
    end

    // headers make up 60% of the beats and the not-last bit is kept rare
    function automatic logic [TDATA_WIDTH-1:0] make_beat();
        logic [TDATA_WIDTH-1:0] data;
        logic [31:0]            pick;
        for (int i = 0; i < TDATA_WIDTH / 32; i++) begin
            data[32*i +: 32] = next_random();
        end
        pick = next_random();
        if (pick[31:16] % 100 < 60) begin
            data[63:56] = 8'hAA;
            data[28]    = (pick[15:12] == 4'd0);
        end else if (data[63:56] == 8'hAA) begin
            data[63:56] = 8'h2A;
        end
        return data;
    endfunction

    // ##############################
    // stimulus
    // ##############################

    initial begin
        logic [31:0] pick;
        logic        fire;
        int          cycle;
        int          idle_cycles;
        ARESETN  = 1'b0;
        s_tdata  = '0;
        s_tvalid = 1'b0;
        m_ready  = 1'b0;
        cycle    = 0;
        repeat (8) @(posedge ACLK);
        #1;
        ARESETN = 1'b1;
        check_bit("s_tready", s_tready, 1'b0);
        check_bit("m_valid", m_valid, 1'b0);
        check_size("received_size", received_size, 32'd0);
        check_count("hit_count", hit_count, 31'd0);
        check_bit("full", full, 1'b0);
        @(posedge ACLK);
        #1;
        check_bit("s_tready", s_tready, 1'b1);
        stimulus_started = 1'b1;

        while (beats_sent < NUM_BEATS) begin
            pick = next_random();
            // long stretches with m_ready low push back into the input
            m_ready = ((cycle % STALL_PERIOD) < STALL_PERIOD - STALL_LENGTH)
                    && (pick[31:30] != 2'b00);
            if (!s_tvalid && beats_sent < NUM_BEATS && pick[29:28] != 2'b00) begin
                s_tdata  = make_beat();
                s_tvalid = 1'b1;
            end
            @(negedge ACLK);
            fire = s_tvalid && s_tready;
            @(posedge ACLK);
            #1;
            if (fire) begin
                model_accept(s_tdata);
                beats_sent++;
                s_tvalid = 1'b0;
            end
            cycle++;
        end

        // the pipeline is empty once m_valid has stayed low for ten cycles
        m_ready     = 1'b1;
        idle_cycles = 0;
        while (idle_cycles < 10) begin
            @(negedge ACLK);
            if (m_valid) begin
                idle_cycles = 0;
            end else begin
                idle_cycles++;
            end
        end
        check_size("received_size", received_size, model_size);
        check_count("hit_count", hit_count, model_hits);
        check_bit("full", full, model_full);
        if (reports_received != run_end_count || !saw_backpressure) begin
            if (reports_received != run_end_count) begin
                $display("received %0d reports but sent %0d run-end headers",
                         reports_received, run_end_count);
            end
            if (!saw_backpressure) begin
                $display("s_tready never fell while m_ready was held low");
            end
            stop_with_failure();
        end else begin
            $display("=== PASS ===");
            $finish;
        end
    end

    // ##############################
    // output monitors
    // ##############################

    always @(negedge ACLK) begin
        if (ARESETN && m_valid && m_ready) begin
            if (expected_reports.size() == 0) begin
                $display("a report arrived with no run-end header left to match it");
                stop_with_failure();
            end else begin
                check_report(m_report, expected_reports.pop_front());
                reports_received++;
            end
        end
    end

    // the model runs ahead of the DUT, so full may never lead it
    always @(negedge ACLK) begin
        if (ARESETN) begin
            if (full_seen) begin
                check_bit("full", full, 1'b1);
            end else if (full) begin
                check_bit("full", full, model_full);
            end
            full_seen = full_seen || full;
            if (stimulus_started && s_tvalid && !s_tready) begin
                saw_backpressure = 1'b1;
            end
        end
    end

endmodule
